/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := mmu_tb
FILELIST  := mmu.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard verilog/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "All tests passed" $(LOG) && ! grep -q "Some tests failed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/mmu_asserts.sv */
// ##############################
// Response protocol checks, bound into the MMU top
// ##############################
`timescale 1ns/1ps

module mmu_asserts (
  input logic               clk_i,
  input logic               reset_i,
  input logic               cmd_v_i,
  input mmu_pkg::mmu_cmd_s  cmd_i,
  input logic               resp_v_i,
  input mmu_pkg::mmu_resp_s resp_i
);

  logic mem_v;
  int   fail_cnt = 0;

  assign mem_v = cmd_v_i &&
                 ((cmd_i.op == mmu_pkg::e_op_load) || (cmd_i.op == mmu_pkg::e_op_store));

  no_resp_in_reset: assert property (@(posedge clk_i) reset_i |-> resp_v_i !== 1'b1)
    else begin
      $error("resp_v_o high during reset");
      fail_cnt = fail_cnt + 1;
    end

  // Miss and faults are mutually exclusive
  one_flag: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_v_i |-> $onehot0({resp_i.tlb_miss, resp_i.load_page_fault, resp_i.store_page_fault,
                           resp_i.load_access_fault, resp_i.store_access_fault}))
    else begin
      $error("more than one miss or fault flag in a response");
      fail_cnt = fail_cnt + 1;
    end

  fixed_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_v_i |-> $past(mem_v, 2))
    else begin
      $error("response without a load or store two cycles earlier");
      fail_cnt = fail_cnt + 1;
    end

endmodule

bind mmu_top mmu_asserts asserts_i (
  .clk_i    (clk_i),
  .reset_i  (reset_i),
  .cmd_v_i  (cmd_v_i),
  .cmd_i    (cmd_i),
  .resp_v_i (resp_v_o),
  .resp_i   (resp_o)
);

/* dv/mmu_tb.sv */
// ##############################
// Testbench for the MMU front end
// Applies the command table and checks each response two cycles later
// ##############################
`timescale 1ns/1ps
`include "mmu_cfg.svh"

module mmu_tb;

  localparam mmu_pkg::mmu_op_e LD     = mmu_pkg::e_op_load;
  localparam mmu_pkg::mmu_op_e ST     = mmu_pkg::e_op_store;
  localparam mmu_pkg::mmu_op_e FILL   = mmu_pkg::e_op_tlb_fill;
  localparam mmu_pkg::mmu_op_e CFG    = mmu_pkg::e_op_cfg_write;
  localparam mmu_pkg::mmu_op_e SFENCE = mmu_pkg::e_op_sfence;

  // Flag order {miss, load pf, store pf, load af, store af}
  localparam logic [4:0] F_NONE = 5'b00000;
  localparam logic [4:0] F_MISS = 5'b10000;
  localparam logic [4:0] F_LPF  = 5'b01000;
  localparam logic [4:0] F_SPF  = 5'b00100;
  localparam logic [4:0] F_LAF  = 5'b00010;
  localparam logic [4:0] F_SAF  = 5'b00001;

  typedef struct packed {
    mmu_pkg::mmu_op_e            op;
    logic [`MMU_VADDR_WIDTH-1:0] vaddr;
    mmu_pkg::mmu_payload_u       payload;
    logic                        kill;
    logic [`MMU_PTAG_WIDTH-1:0]  exp_ptag;
    logic [4:0]                  exp_flags;
  } vector_s;

  typedef struct packed {
    int unsigned idx;
    int unsigned stamp;
  } pending_s;

  logic               clk = 1'b0;
  logic               reset;
  logic               cmd_v;
  mmu_pkg::mmu_cmd_s  cmd;
  logic               kill;
  logic               resp_v;
  mmu_pkg::mmu_resp_s resp;

  vector_s     vec_q[$];
  string       name_q[$];
  pending_s    pend_q[$];
  int unsigned cycle_cnt;
  int unsigned limit;
  int          errors;
  int          checks;
  integer      seed;

  mmu_top dut_i (
    .clk_i    (clk),
    .reset_i  (reset),
    .cmd_v_i  (cmd_v),
    .cmd_i    (cmd),
    .kill_i   (kill),
    .resp_v_o (resp_v),
    .resp_o   (resp)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  function automatic mmu_pkg::mmu_payload_u pte_word(
    input logic [`MMU_PTAG_WIDTH-1:0] ptag,
    input logic [2:0]                 uwd
  );
    mmu_pkg::mmu_payload_u p;
    p = '0;
    p.pte.ptag = ptag;
    {p.pte.u, p.pte.w, p.pte.d} = uwd;
    return p;
  endfunction

  // Mode bits given as {sum, translation_en, uncached_mode}
  function automatic mmu_pkg::mmu_payload_u cfg_word(
    input mmu_pkg::mmu_priv_e priv,
    input logic [2:0]         mode
  );
    mmu_pkg::mmu_payload_u p;
    p = '0;
    p.cfg.priv = priv;
    {p.cfg.sum, p.cfg.translation_en, p.cfg.uncached_mode} = mode;
    return p;
  endfunction

  task automatic add_vector(
    input string                      name,
    input mmu_pkg::mmu_op_e           op,
    input logic [`MMU_VTAG_WIDTH-1:0] vtag,
    input mmu_pkg::mmu_payload_u      payload,
    input logic                       kill_next,
    input logic [`MMU_PTAG_WIDTH-1:0] exp_ptag,
    input logic [4:0]                 exp_flags
  );
    vector_s                           v;
    logic [`MMU_PAGE_OFFSET_WIDTH-1:0] offset;
    offset      = `MMU_PAGE_OFFSET_WIDTH'($random(seed));
    v.op        = op;
    v.vaddr     = {vtag, offset};
    v.payload   = payload;
    v.kill      = kill_next;
    v.exp_ptag  = exp_ptag;
    v.exp_flags = exp_flags;
    vec_q.push_back(v);
    name_q.push_back(name);
  endtask

  task automatic build_table();
    add_vector("bare_load", LD, 27'h0001234, '0, 1'b0, 28'h0001234, F_NONE);
    add_vector("cfg_s_on", CFG, '0, cfg_word(mmu_pkg::e_priv_s, 3'b010), 1'b0, '0, F_NONE);
    add_vector("s_miss", LD, 27'h100, '0, 1'b0, '0, F_MISS);
    add_vector("fill_a", FILL, 27'h100, pte_word(28'h0055000, 3'b011), 1'b0, '0, F_NONE);
    add_vector("s_hit_load", LD, 27'h100, '0, 1'b0, 28'h0055000, F_NONE);
    add_vector("s_hit_store", ST, 27'h100, '0, 1'b0, 28'h0055000, F_NONE);
    add_vector("sfence_a", SFENCE, '0, '0, 1'b0, '0, F_NONE);
    add_vector("s_miss_again", LD, 27'h100, '0, 1'b0, '0, F_MISS);
    add_vector("fill_user", FILL, 27'h200, pte_word(28'h0066000, 3'b111), 1'b0, '0, F_NONE);
    add_vector("fill_sup", FILL, 27'h201, pte_word(28'h0067000, 3'b011), 1'b0, '0, F_NONE);
    add_vector("fill_ro", FILL, 27'h202, pte_word(28'h0068000, 3'b001), 1'b0, '0, F_NONE);
    add_vector("fill_clean", FILL, 27'h203, pte_word(28'h0069000, 3'b010), 1'b0, '0, F_NONE);
    add_vector("s_user_nosum", LD, 27'h200, '0, 1'b0, 28'h0066000, F_LPF);
    add_vector("cfg_s_sum", CFG, '0, cfg_word(mmu_pkg::e_priv_s, 3'b110), 1'b0, '0, F_NONE);
    add_vector("s_user_sum", LD, 27'h200, '0, 1'b0, 28'h0066000, F_NONE);
    add_vector("st_readonly", ST, 27'h202, '0, 1'b0, 28'h0068000, F_SPF);
    add_vector("st_clean", ST, 27'h203, '0, 1'b0, 28'h0069000, F_SPF);
    add_vector("cfg_u", CFG, '0, cfg_word(mmu_pkg::e_priv_u, 3'b010), 1'b0, '0, F_NONE);
    add_vector("u_sup_page", LD, 27'h201, '0, 1'b0, 28'h0067000, F_LPF);
    // Domain 1 page, then a page inside the uncached window
    add_vector("fill_dom", FILL, 27'h300, pte_word(28'h2070000, 3'b111), 1'b0, '0, F_NONE);
    add_vector("fill_unc", FILL, 27'h301, pte_word(28'h1071000, 3'b111), 1'b0, '0, F_NONE);
    add_vector("dom_load", LD, 27'h300, '0, 1'b0, 28'h2070000, F_LAF);
    add_vector("dom_store", ST, 27'h300, '0, 1'b0, 28'h2070000, F_SAF);
    add_vector("cfg_u_unc", CFG, '0, cfg_word(mmu_pkg::e_priv_u, 3'b011), 1'b0, '0, F_NONE);
    add_vector("unc_bit_set", LD, 27'h301, '0, 1'b0, 28'h1071000, F_NONE);
    add_vector("unc_bit_clear", LD, 27'h200, '0, 1'b0, 28'h0066000, F_LAF);
    add_vector("unc_pf_wins", LD, 27'h201, '0, 1'b0, 28'h0067000, F_LPF);
    add_vector("unc_store_clear", ST, 27'h200, '0, 1'b0, 28'h0066000, F_SAF);
    add_vector("kill_load", LD, 27'h301, '0, 1'b1, 28'h1071000, F_NONE);
    add_vector("after_kill", LD, 27'h301, '0, 1'b0, 28'h1071000, F_NONE);
    add_vector("cfg_m_off", CFG, '0, cfg_word(mmu_pkg::e_priv_m, 3'b000), 1'b0, '0, F_NONE);
    add_vector("m_load_dom", LD, 27'h4001234, '0, 1'b0, 28'h4001234, F_LAF);
  endtask

  initial begin : stimulus
    vector_s  v;
    pending_s p;
    logic     kill_next;
    seed      = 31;
    reset     = 1'b1;
    cmd_v     = 1'b0;
    cmd       = '0;
    kill      = 1'b0;
    cycle_cnt = 0;
    errors    = 0;
    checks    = 0;
    kill_next = 1'b0;
    build_table();
    limit = vec_q.size() + 20;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    for (int i = 0; i < vec_q.size(); i++) begin
      @(posedge clk);
      v = vec_q[i];
      cmd_v         <= 1'b1;
      cmd.op        <= v.op;
      cmd.vaddr     <= v.vaddr;
      cmd.payload   <= v.payload;
      kill          <= kill_next;
      kill_next = v.kill;
      // Response lands at the negedge two cycles after capture
      if ((v.op == LD || v.op == ST) && !v.kill) begin
        p.idx   = i;
        p.stamp = cycle_cnt + 3;
        pend_q.push_back(p);
      end
    end
    @(posedge clk);
    cmd_v <= 1'b0;
    kill  <= kill_next;
    @(posedge clk);
    kill <= 1'b0;
    while (pend_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    errors = errors + dut_i.asserts_i.fail_cnt;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  always @(negedge clk) begin : response_check
    pending_s                                          p;
    vector_s                                           v;
    logic [`MMU_PTAG_WIDTH+`MMU_PAGE_OFFSET_WIDTH-1:0] exp_paddr;
    logic [4:0]                                        flags;
    flags = {resp.tlb_miss, resp.load_page_fault, resp.store_page_fault,
             resp.load_access_fault, resp.store_access_fault};
    if (pend_q.size() != 0 && pend_q[0].stamp == cycle_cnt) begin
      p = pend_q.pop_front();
      v = vec_q[p.idx];
      exp_paddr = {v.exp_ptag, v.vaddr[`MMU_PAGE_OFFSET_WIDTH-1:0]};
      checks++;
      assert (resp_v === 1'b1) else begin
        errors++;
        $display("No response for %s arrived two cycles after its strobe", name_q[p.idx]);
      end
      assert (flags === v.exp_flags) else begin
        errors++;
        $display("Error: %s flags expected %b actual %b", name_q[p.idx], v.exp_flags, flags);
      end
      assert (resp.vaddr === v.vaddr) else begin
        errors++;
        $display("Error: %s vaddr expected %h actual %h", name_q[p.idx], v.vaddr, resp.vaddr);
      end
      // paddr is only defined on a hit or in bare mode
      if (!v.exp_flags[4]) begin
        assert (resp.paddr === exp_paddr) else begin
          errors++;
          $display("Error: %s paddr expected %h actual %h", name_q[p.idx], exp_paddr,
                   resp.paddr);
        end
      end
    end else begin
      assert (resp_v !== 1'b1) else begin
        errors++;
        $display("A response came out in cycle %0d with no load or store due", cycle_cnt);
      end
    end
  end

  initial begin : watchdog
    @(posedge clk);
    while (cycle_cnt < limit) begin
      @(posedge clk);
    end
    $display("Timeout after %0d cycles, the run did not finish", limit);
    $display("Some tests failed");
    $finish;
  end

endmodule

/* mmu.f */
+incdir+verilog
verilog/mmu_pkg.sv
verilog/mmu_cfg_regs.sv
verilog/mmu_dtlb.sv
verilog/mmu_fault_check.sv
verilog/mmu_top.sv
dv/mmu_asserts.sv
dv/mmu_tb.sv

/* verilog/mmu_cfg.svh */
// ############################
// Widths, TLB depth and address map of the MMU front end
// Included by the package and by any module that sizes a vector
// ############################
`ifndef MMU_CFG_SVH
`define MMU_CFG_SVH

// Sv39 virtual address split
`define MMU_VADDR_WIDTH       39
`define MMU_PAGE_OFFSET_WIDTH 12
`define MMU_VTAG_WIDTH        27

// Physical tag, 40-bit paddr with the page offset
`define MMU_PTAG_WIDTH        28

// One command payload word
`define MMU_PAYLOAD_WIDTH     32

`define MMU_TLB_ENTRIES       8

// Domain id sits in the top ptag bits
`define MMU_DID_WIDTH         3
`define MMU_UNCACHED_BIT      24

`endif

/* verilog/mmu_cfg_regs.sv */
// ############################
// Privilege and mode register, loaded by cfg_write commands
// ############################
`timescale 1ns/1ps

module mmu_cfg_regs (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              cmd_v_i,
  input  mmu_pkg::mmu_cmd_s cmd_i,
  output mmu_pkg::mmu_cfg_s cfg_o
);

  mmu_pkg::mmu_cfg_word_s cfg_word;
  mmu_pkg::mmu_cfg_s      cfg_q;
  logic                   cfg_write_v;

  // Payload read through its config view
  assign cfg_word    = cmd_i.payload.cfg;
  assign cfg_write_v = cmd_v_i && (cmd_i.op == mmu_pkg::e_op_cfg_write);

  // Comes out of reset in M mode, bare
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cfg_q.priv           <= mmu_pkg::e_priv_m;
      cfg_q.sum            <= 1'b0;
      cfg_q.translation_en <= 1'b0;
      cfg_q.uncached_mode  <= 1'b0;
    end else if (cfg_write_v) begin
      cfg_q.priv           <= cfg_word.priv;
      cfg_q.sum            <= cfg_word.sum;
      cfg_q.translation_en <= cfg_word.translation_en;
      cfg_q.uncached_mode  <= cfg_word.uncached_mode;
    end
  end

  assign cfg_o = cfg_q;

endmodule

/* verilog/mmu_dtlb.sv */
// ############################
// Fully associative data TLB, round-robin fill, one-cycle lookup
// ############################
`timescale 1ns/1ps
`include "mmu_cfg.svh"

module mmu_dtlb (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              cmd_v_i,
  input  mmu_pkg::mmu_cmd_s cmd_i,
  output logic              hit_o,
  output mmu_pkg::mmu_pte_s entry_o
);

  localparam int ENTRIES   = `MMU_TLB_ENTRIES;
  localparam int PTR_WIDTH = $clog2(ENTRIES);

  logic [`MMU_VTAG_WIDTH-1:0] tag_q [ENTRIES];
  mmu_pkg::mmu_pte_s          pte_q [ENTRIES];
  logic [ENTRIES-1:0]         valid_q;
  logic [PTR_WIDTH-1:0]       fill_ptr_q;

  logic                       fill_v;
  logic                       sfence_v;
  logic                       lookup_v;
  logic [`MMU_VTAG_WIDTH-1:0] vtag;
  logic [ENTRIES-1:0]         match;
  mmu_pkg::mmu_pte_s          match_pte;

  assign fill_v   = cmd_v_i && (cmd_i.op == mmu_pkg::e_op_tlb_fill);
  assign sfence_v = cmd_v_i && (cmd_i.op == mmu_pkg::e_op_sfence);
  assign lookup_v = cmd_v_i &&
                    ((cmd_i.op == mmu_pkg::e_op_load) || (cmd_i.op == mmu_pkg::e_op_store));
  assign vtag     = cmd_i.vaddr[`MMU_VADDR_WIDTH-1:`MMU_PAGE_OFFSET_WIDTH];

  // Tags are unique between flushes, so at most one match
  always_comb begin
    match_pte = '0;
    for (int i = 0; i < ENTRIES; i++) begin
      match[i] = valid_q[i] && (tag_q[i] == vtag);
      if (match[i]) begin
        match_pte = pte_q[i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q    <= '0;
      fill_ptr_q <= '0;
    end else if (sfence_v) begin
      valid_q <= '0;
    end else if (fill_v) begin
      valid_q[fill_ptr_q] <= 1'b1;
      if (fill_ptr_q == PTR_WIDTH'(ENTRIES - 1)) begin
        fill_ptr_q <= '0;
      end else begin
        fill_ptr_q <= fill_ptr_q + 1'b1;
      end
    end
  end

  // Storage arrays
  always_ff @(posedge clk_i) begin
    if (fill_v) begin
      tag_q[fill_ptr_q] <= vtag;
      pte_q[fill_ptr_q] <= cmd_i.payload.pte;
    end
  end

  // Lookup result for the stage-one command
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      hit_o <= 1'b0;
    end else begin
      hit_o <= lookup_v && (|match);
    end
  end

  always_ff @(posedge clk_i) begin
    if (lookup_v) begin
      entry_o <= match_pte;
    end
  end

endmodule

/* verilog/mmu_fault_check.sv */
// ############################
// Stage-two permission and access checks, registered response
// ############################
`timescale 1ns/1ps
`include "mmu_cfg.svh"

module mmu_fault_check (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        s1_v_i,
  input  logic                        s1_store_i,
  input  logic [`MMU_VADDR_WIDTH-1:0] s1_vaddr_i,
  input  logic                        kill_i,
  input  mmu_pkg::mmu_cfg_s           cfg_i,
  input  logic                        hit_i,
  input  mmu_pkg::mmu_pte_s           entry_i,
  output logic                        resp_v_o,
  output mmu_pkg::mmu_resp_s          resp_o
);

  localparam int PADDR_WIDTH = `MMU_PTAG_WIDTH + `MMU_PAGE_OFFSET_WIDTH;

  logic                       trans_active;
  logic                       tlb_miss;
  logic                       priv_fault;
  logic                       write_fault;
  logic                       load_pf;
  logic                       store_pf;
  logic [PADDR_WIDTH-1:0]     paddr;
  logic [`MMU_PTAG_WIDTH-1:0] ptag;
  logic                       did_fault;
  logic                       mode_fault;
  logic                       access_fault;
  mmu_pkg::mmu_resp_s         resp_d;

  // M mode always runs bare
  assign trans_active = cfg_i.translation_en && (cfg_i.priv != mmu_pkg::e_priv_m);
  assign tlb_miss     = trans_active && !hit_i;

  assign paddr = (trans_active && hit_i) ?
                 {entry_i.ptag, s1_vaddr_i[`MMU_PAGE_OFFSET_WIDTH-1:0]} :
                 PADDR_WIDTH'(s1_vaddr_i);
  assign ptag  = paddr[PADDR_WIDTH-1:`MMU_PAGE_OFFSET_WIDTH];

  // S mode touches user pages only with SUM
  assign priv_fault  = trans_active && hit_i &&
                       (((cfg_i.priv == mmu_pkg::e_priv_s) && !cfg_i.sum && entry_i.u) ||
                        ((cfg_i.priv == mmu_pkg::e_priv_u) && !entry_i.u));
  assign write_fault = trans_active && hit_i && s1_store_i && (!entry_i.w || !entry_i.d);
  assign load_pf     = !s1_store_i && priv_fault;
  assign store_pf    = s1_store_i && (priv_fault || write_fault);

  // Only domain zero is reachable
  assign did_fault    = ptag[`MMU_PTAG_WIDTH-1 -: `MMU_DID_WIDTH] != '0;
  assign mode_fault   = cfg_i.uncached_mode && !ptag[`MMU_UNCACHED_BIT];
  assign access_fault = !tlb_miss && !load_pf && !store_pf && (did_fault || mode_fault);

  always_comb begin
    resp_d.vaddr              = s1_vaddr_i;
    resp_d.paddr              = paddr;
    resp_d.tlb_miss           = tlb_miss;
    resp_d.load_page_fault    = load_pf;
    resp_d.store_page_fault   = store_pf;
    resp_d.load_access_fault  = access_fault && !s1_store_i;
    resp_d.store_access_fault = access_fault && s1_store_i;
  end

  // Kill squashes whatever sits in stage one
  always_ff @(posedge clk_i) begin
    if (reset_i || kill_i) begin
      resp_v_o <= 1'b0;
      resp_o   <= '0;
    end else begin
      resp_v_o <= s1_v_i;
      resp_o   <= resp_d;
    end
  end

endmodule

/* verilog/mmu_pkg.sv */
// ############################
// Command, response and TLB entry types of the MMU front end
// ############################
`include "mmu_cfg.svh"

package mmu_pkg;

  typedef enum logic [2:0] {
    e_op_load      = 3'd0,
    e_op_store     = 3'd1,
    e_op_tlb_fill  = 3'd2,
    e_op_cfg_write = 3'd3,
    e_op_sfence    = 3'd4
  } mmu_op_e;

  typedef enum logic [1:0] {
    e_priv_u = 2'd0,
    e_priv_s = 2'd1,
    e_priv_m = 2'd3
  } mmu_priv_e;

  // Leaf PTE as carried by a fill command
  typedef struct packed {
    logic [`MMU_PAYLOAD_WIDTH-`MMU_PTAG_WIDTH-4:0] rsvd;
    logic [`MMU_PTAG_WIDTH-1:0]                    ptag;
    logic                                          u;
    logic                                          w;
    logic                                          d;
  } mmu_pte_s;

  typedef struct packed {
    logic [`MMU_PAYLOAD_WIDTH-6:0] rsvd;
    mmu_priv_e                     priv;
    logic                          sum;
    logic                          translation_en;
    logic                          uncached_mode;
  } mmu_cfg_word_s;

  // Same word seen by fill and cfg_write commands
  typedef union packed {
    mmu_pte_s      pte;
    mmu_cfg_word_s cfg;
  } mmu_payload_u;

  typedef struct packed {
    mmu_op_e                     op;
    logic [`MMU_VADDR_WIDTH-1:0] vaddr;
    mmu_payload_u                payload;
  } mmu_cmd_s;

  typedef struct packed {
    logic [`MMU_VADDR_WIDTH-1:0]                        vaddr;
    logic [`MMU_PTAG_WIDTH+`MMU_PAGE_OFFSET_WIDTH-1:0] paddr;
    logic                                               tlb_miss;
    logic                                               load_page_fault;
    logic                                               store_page_fault;
    logic                                               load_access_fault;
    logic                                               store_access_fault;
  } mmu_resp_s;

  typedef struct packed {
    mmu_priv_e priv;
    logic      sum;
    logic      translation_en;
    logic      uncached_mode;
  } mmu_cfg_s;

endpackage

/* verilog/mmu_top.sv */
// ############################
// MMU front end top, two-stage load/store translation
// ############################
`timescale 1ns/1ps
`include "mmu_cfg.svh"

module mmu_top (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               cmd_v_i,
  input  mmu_pkg::mmu_cmd_s  cmd_i,
  input  logic               kill_i,
  output logic               resp_v_o,
  output mmu_pkg::mmu_resp_s resp_o
);

  mmu_pkg::mmu_cfg_s           cfg;
  logic                        tlb_hit;
  mmu_pkg::mmu_pte_s           tlb_entry;
  logic                        mem_v;
  logic                        s1_v_q;
  logic                        s1_store_q;
  logic [`MMU_VADDR_WIDTH-1:0] s1_vaddr_q;

  assign mem_v = cmd_v_i &&
                 ((cmd_i.op == mmu_pkg::e_op_load) || (cmd_i.op == mmu_pkg::e_op_store));

  // Stage one holds loads and stores only
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s1_v_q     <= 1'b0;
      s1_store_q <= 1'b0;
    end else begin
      s1_v_q     <= mem_v;
      s1_store_q <= mem_v && (cmd_i.op == mmu_pkg::e_op_store);
    end
  end

  always_ff @(posedge clk_i) begin
    s1_vaddr_q <= cmd_i.vaddr;
  end

  mmu_cfg_regs cfg_regs_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .cmd_v_i (cmd_v_i),
    .cmd_i   (cmd_i),
    .cfg_o   (cfg)
  );

  mmu_dtlb dtlb_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .cmd_v_i (cmd_v_i),
    .cmd_i   (cmd_i),
    .hit_o   (tlb_hit),
    .entry_o (tlb_entry)
  );

  mmu_fault_check fault_check_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .s1_v_i     (s1_v_q),
    .s1_store_i (s1_store_q),
    .s1_vaddr_i (s1_vaddr_q),
    .kill_i     (kill_i),
    .cfg_i      (cfg),
    .hit_i      (tlb_hit),
    .entry_i    (tlb_entry),
    .resp_v_o   (resp_v_o),
    .resp_o     (resp_o)
  );

endmodule
